//--- Bender.yml
package:
  name: stack_unit

sources:
  - logic/stackPkg.sv
  - logic/stackIfc.sv
  - logic/frameTracker.sv
  - logic/superStack.sv
  - logic/faultMonitor.sv
  - logic/stackUnit.sv
  - target: test
    files:
      - verif/stackUnitTb.sv

//--- logic/faultMonitor.sv
////////////////////////////////////////////////////////////
// Output stage of the operand stack. Registers the result
// view to the outputs, latches the first fault status and
// counts faults, saturating at the counter's maximum.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module faultMonitor import stackPkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  stackViewIf.monitor               view,
  output stackIdx_t                 index,
  output stackWord_t                top,
  output stackWord_t                next,
  output stackWord_t                third,
  output stackStatus_t              status,
  output logic                      faultSeen,
  output stackStatus_t              firstFault,
  output logic [faultCountBits-1:0] faultCount
);

  logic isFault;

  // Underflow is only a fault when the op was refused, so the index held
  assign isFault = (view.status == stOverflow) || (view.status == stBadIndex) ||
                   (view.status == stBadOffset) ||
                   ((view.status == stUnderflow) && (view.index == index));

  always_ff @(posedge clk) begin
    if (reset) begin
      index      <= '0;
      status     <= stEmpty;
      faultSeen  <= 1'b0;
      firstFault <= stNone;
      faultCount <= '0;
    end else begin
      index  <= view.index;
      status <= view.status;
      if (isFault && !faultSeen) begin
        faultSeen  <= 1'b1;
        firstFault <= view.status;
      end
      if (isFault && (faultCount != faultCountMax))
        faultCount <= faultCount + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    top   <= view.top;
    next  <= view.next;
    third <= view.third;
  end

endmodule

`default_nettype wire

//--- logic/frameTracker.sv
////////////////////////////////////////////////////////////
// Command front end of the operand stack. Registers each
// external command onto the stack bus and keeps the saved
// call frames that set the underflow and base limits.
// A frame command applies from the following command on.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frameTracker import stackPkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  stackOp_t     op,
  input  frameOp_t     frameOp,
  input  stackWord_t   data,
  input  stackIdx_t    offset,
  stackCtrlIf.producer ctrl,
  stackViewIf.tracker  view
);

  frameOp_t            frameReq;     // Frame command beside the op on ctrl
  stackIdx_t           frameArg;
  frameOp_t            frameAct;     // Frame command being applied
  stackIdx_t           actArg;
  stackIdx_t           underReg;
  stackIdx_t           baseReg;
  stackIdx_t           savedUnder [frameSlots];
  stackIdx_t           savedBase [frameSlots];
  logic [slotBits-1:0] slotCount;
  logic [slotBits-1:0] slotBelow;
  logic                enterGo;
  logic                leaveGo;
  stackIdx_t           newUnder;
  stackIdx_t           newBase;

  // Full or empty slot array turns the frame command into a no-op
  assign enterGo   = (frameAct == frameEnter) && (slotCount < frameSlots);
  assign leaveGo   = (frameAct == frameLeave) && (slotCount != '0);
  assign slotBelow = slotCount - 1'b1;

  // The op that came with the frame command has already executed, so
  // view.index here is the depth the new frame opens at
  always_comb begin
    newUnder = underReg;
    newBase  = baseReg;
    if (enterGo) begin
      newUnder = view.index - actArg;  // Arguments join the new frame
      newBase  = underReg;
    end else if (leaveGo) begin
      newUnder = savedUnder[slotBelow[slotBits-2:0]];
      newBase  = savedBase[slotBelow[slotBits-2:0]];
    end
  end

  assign ctrl.underflowLimit = newUnder;
  assign ctrl.baseLimit      = newBase;

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl.op   <= opNone;
      frameReq  <= frameNone;
      frameAct  <= frameNone;
      underReg  <= '0;
      baseReg   <= '0;
      slotCount <= '0;
    end else begin
      ctrl.op  <= op;
      frameReq <= frameOp;
      frameAct <= frameReq;
      underReg <= newUnder;
      baseReg  <= newBase;
      if (enterGo)
        slotCount <= slotCount + 1'b1;
      else if (leaveGo)
        slotCount <= slotBelow;
    end
  end

  always_ff @(posedge clk) begin
    ctrl.data   <= data;
    ctrl.offset <= offset;
    frameArg    <= offset;
    actArg      <= frameArg;
    if (enterGo) begin
      savedUnder[slotCount[slotBits-2:0]] <= underReg;
      savedBase[slotCount[slotBits-2:0]]  <= baseReg;
    end
  end

  // Arguments of a new frame must already sit on the stack
  frameArgsFit: assert property (@(posedge clk) disable iff (reset)
    enterGo |-> (actArg <= view.index))
    else $error("Frame opened with %0d arguments at index %0d", actArg, view.index);

endmodule

`default_nettype wire

//--- logic/stackIfc.sv
////////////////////////////////////////////////////////////
// Internal buses of the operand stack subsystem.
// stackCtrlIf carries one command per cycle into the stack,
// stackViewIf carries the stack's result view back out.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface stackCtrlIf import stackPkg::*; ();

  stackOp_t   op;              // opNone when idle
  stackWord_t data;
  stackIdx_t  offset;          // Index target or offset below frame
  stackIdx_t  underflowLimit;  // Bottom of the current frame
  stackIdx_t  baseLimit;       // Bottom of the caller's frame

  modport producer (
    output op, data, offset, underflowLimit, baseLimit
  );

  modport stack (
    input op, data, offset, underflowLimit, baseLimit
  );

endinterface

interface stackViewIf import stackPkg::*; ();

  stackIdx_t    index;
  stackWord_t   top;
  stackWord_t   next;
  stackWord_t   third;
  stackStatus_t status;

  modport stack (
    output index, top, next, third, status
  );

  // Frame opening only needs the current depth
  modport tracker (
    input index
  );

  modport monitor (
    input index, top, next, third, status
  );

endinterface

`default_nettype wire

//--- logic/stackPkg.sv
////////////////////////////////////////////////////////////
// Shared sizes, types and encodings of the operand stack
// subsystem. Modules pull these in with a wildcard import
// in their header.
////////////////////////////////////////////////////////////
`default_nettype none

package stackPkg;

  localparam int dataWidth      = 8;
  localparam int depthBits      = 4;
  localparam int maxStack       = (1 << (depthBits + 1)) - 1;  // Also the full index value
  localparam int frameSlots     = 4;                           // Saved call frames
  localparam int slotBits       = $clog2(frameSlots) + 1;      // Slot count 0..frameSlots
  localparam int faultCountBits = 8;
  localparam int faultCountMax  = (1 << faultCountBits) - 1;

  typedef logic [depthBits:0]   stackIdx_t;   // Index, limit or offset
  typedef logic [dataWidth-1:0] stackWord_t;

  // Three-bit opcodes of the stack operations
  typedef enum logic [2:0] {
    opNone, opPush, opPop, opReplace,
    opIndexReset, opIndexPush, opUnderGet, opUnderSet
  } stackOp_t;

  typedef enum logic [1:0] {
    frameNone, frameEnter, frameLeave
  } frameOp_t;

  typedef enum logic [2:0] {
    stNone, stEmpty, stFull, stUnderflow,
    stOverflow, stBadIndex, stBadOffset
  } stackStatus_t;

endpackage

`default_nettype wire

//--- logic/stackUnit.sv
////////////////////////////////////////////////////////////
// Top level of the operand stack subsystem. Commands enter
// the frame tracker, run through the stack core and leave
// through the fault monitor, three edges from input to output.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stackUnit import stackPkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  stackOp_t                  op,
  input  frameOp_t                  frameOp,
  input  stackWord_t                data,
  input  stackIdx_t                 offset,
  output stackIdx_t                 index,
  output stackWord_t                top,
  output stackWord_t                next,
  output stackWord_t                third,
  output stackStatus_t              status,
  output logic                      faultSeen,
  output stackStatus_t              firstFault,
  output logic [faultCountBits-1:0] faultCount
);

  stackCtrlIf ctrlBus ();
  stackViewIf viewBus ();

  frameTracker trackerInst (
    .clk     (clk),
    .reset   (reset),
    .op      (op),
    .frameOp (frameOp),
    .data    (data),
    .offset  (offset),
    .ctrl    (ctrlBus.producer),
    .view    (viewBus.tracker)
  );

  superStack stackInst (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrlBus.stack),
    .view  (viewBus.stack)
  );

  faultMonitor monitorInst (
    .clk        (clk),
    .reset      (reset),
    .view       (viewBus.monitor),
    .index      (index),
    .top        (top),
    .next       (next),
    .third      (third),
    .status     (status),
    .faultSeen  (faultSeen),
    .firstFault (firstFault),
    .faultCount (faultCount)
  );

endmodule

`default_nettype wire

//--- logic/superStack.sv
////////////////////////////////////////////////////////////
// Operand stack core. Executes one operation per cycle from
// the control bus and publishes the index, the top three
// words and a status code on the view bus one edge later.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module superStack import stackPkg::*; (
  input  logic      clk,
  input  logic      reset,
  stackCtrlIf.stack ctrl,
  stackViewIf.stack view
);

  stackWord_t         stackMem [maxStack];
  stackIdx_t          nextIdx;
  stackIdx_t          wrAddr;
  stackWord_t         wrData;
  logic               wrEn;
  logic               opOk;
  logic               getHit;     // Top shows an entry below the frame
  stackStatus_t       errStatus;
  stackIdx_t          frameSpan;
  stackIdx_t          belowAddr;
  logic [dataWidth:0] popNeed;

  // Status from depth alone, used after every successful op
  function automatic stackStatus_t levelStatus(input stackIdx_t depth, input stackIdx_t limit);
    if (depth == maxStack)
      return stFull;
    else if (depth == limit)
      return stEmpty;
    else if (depth < limit)
      return stUnderflow;
    return stNone;
  endfunction

  // Word at a given depth below the new index, with the write of this cycle forwarded
  function automatic stackWord_t slotWord(input stackIdx_t depth);
    stackIdx_t addr;
    addr = nextIdx - depth;
    if (nextIdx < depth)
      return '0;  // Nothing there yet
    else if (wrEn && (wrAddr == addr))
      return wrData;
    return stackMem[addr];
  endfunction

  assign frameSpan = ctrl.underflowLimit - ctrl.baseLimit;
  assign belowAddr = ctrl.underflowLimit - 1'b1 - ctrl.offset;
  assign popNeed   = ctrl.data + 1'b1 + ctrl.underflowLimit;  // Lowest index a pop may start from

  always_comb begin
    opOk      = 1'b1;
    errStatus = stNone;
    nextIdx   = view.index;
    wrEn      = 1'b0;
    wrAddr    = view.index;
    wrData    = ctrl.data;
    getHit    = 1'b0;
    case (ctrl.op)
      opNone: ;
      opPush:
        if (view.index == maxStack) begin
          opOk      = 1'b0;
          errStatus = stOverflow;
        end else begin
          wrEn    = 1'b1;
          nextIdx = view.index + 1'b1;
        end
      opPop:
        if ((dataWidth+1)'(view.index) < popNeed) begin
          opOk      = 1'b0;  // Would drop into the caller's frame
          errStatus = stUnderflow;
        end else begin
          nextIdx = view.index - stackIdx_t'(ctrl.data) - 1'b1;
        end
      opReplace:
        if (view.index <= ctrl.underflowLimit) begin
          opOk      = 1'b0;
          errStatus = stUnderflow;
        end else begin
          wrEn   = 1'b1;
          wrAddr = view.index - 1'b1;
        end
      opIndexReset:
        if (view.index < ctrl.offset) begin
          opOk      = 1'b0;
          errStatus = stBadIndex;
        end else begin
          nextIdx = ctrl.offset;
        end
      opIndexPush:
        if (view.index < ctrl.offset) begin
          opOk      = 1'b0;
          errStatus = stBadIndex;
        end else if (ctrl.offset == maxStack) begin
          opOk      = 1'b0;
          errStatus = stOverflow;
        end else begin
          wrEn    = 1'b1;
          wrAddr  = ctrl.offset;
          nextIdx = ctrl.offset + 1'b1;
        end
      opUnderGet:
        if (frameSpan <= ctrl.offset) begin
          opOk      = 1'b0;
          errStatus = stBadOffset;
        end else begin
          getHit = 1'b1;
        end
      opUnderSet:
        if (frameSpan <= ctrl.offset) begin
          opOk      = 1'b0;
          errStatus = stBadOffset;
        end else begin
          wrEn   = 1'b1;
          wrAddr = belowAddr;
        end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wrEn)
      stackMem[wrAddr] <= wrData;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      view.index  <= '0;
      view.status <= stEmpty;
    end else begin
      view.index <= nextIdx;
      if (!opOk)
        view.status <= errStatus;
      else if (ctrl.op == opUnderGet || ctrl.op == opUnderSet)
        view.status <= stNone;
      else
        view.status <= levelStatus(nextIdx, ctrl.underflowLimit);
    end
  end

  // A failed op leaves the window as it was
  always_ff @(posedge clk) begin
    if (opOk) begin
      view.top   <= getHit ? stackMem[belowAddr] : slotWord(stackIdx_t'(1));
      view.next  <= slotWord(stackIdx_t'(2));
      view.third <= slotWord(stackIdx_t'(3));
    end
  end

  // Writes stay inside the memory and the index grows by at most one entry per op
  indexBounded: assert property (@(posedge clk) disable iff (reset)
    (!wrEn || (wrAddr < maxStack)) && (nextIdx <= view.index + 1))
    else $error("Write at %0d or index step %0d -> %0d out of bounds",
                wrAddr, view.index, nextIdx);

  opKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(ctrl.op))
    else $error("Unknown stack op on control bus");

endmodule

`default_nettype wire

//--- verif/stackTrace.txt
# op frameOp data offset | expIndex expTop expStatus expFaultCount, all hex, one step per line
# op 0 none 1 push 2 pop 3 replace 4 idxReset 5 idxPush 6 get 7 set, status 0 none 1 empty
0 0 00 00  00 00 1 00
1 0 11 00  01 11 0 00
1 0 22 00  02 22 0 00
1 0 33 00  03 33 0 00
1 0 44 00  04 44 0 00
2 0 01 00  02 22 0 00
3 0 55 00  02 55 0 00
2 0 00 00  01 11 0 00
2 0 01 00  01 11 3 01
2 0 00 00  00 00 1 01
# index reset and index push
1 0 66 00  01 66 0 01
1 0 77 00  02 77 0 01
1 0 88 00  03 88 0 01
4 0 00 02  02 77 0 01
4 0 00 04  02 77 5 02
5 0 99 00  01 99 0 02
# call frame with one argument
1 0 a1 00  02 a1 0 02
1 0 a2 00  03 a2 0 02
1 0 a3 00  04 a3 0 02
0 1 00 01  04 a3 0 02
2 0 00 00  03 a2 1 02
2 0 00 00  03 a2 3 03
6 0 00 02  03 99 0 03
7 0 b1 01  03 a2 0 03
6 0 00 01  03 b1 0 03
6 0 00 03  03 b1 6 04
0 2 00 00  03 a2 1 04
0 0 00 00  03 a2 0 04
2 0 02 00  00 00 1 04
# fill to the top, then overflow
1 0 c1 00  01 c1 0 04
1 0 c2 00  02 c2 0 04
1 0 c3 00  03 c3 0 04
1 0 c4 00  04 c4 0 04
1 0 c5 00  05 c5 0 04
1 0 c6 00  06 c6 0 04
1 0 c7 00  07 c7 0 04
1 0 c8 00  08 c8 0 04
1 0 c9 00  09 c9 0 04
1 0 ca 00  0a ca 0 04
1 0 cb 00  0b cb 0 04
1 0 cc 00  0c cc 0 04
1 0 cd 00  0d cd 0 04
1 0 ce 00  0e ce 0 04
1 0 cf 00  0f cf 0 04
1 0 d0 00  10 d0 0 04
1 0 d1 00  11 d1 0 04
1 0 d2 00  12 d2 0 04
1 0 d3 00  13 d3 0 04
1 0 d4 00  14 d4 0 04
1 0 d5 00  15 d5 0 04
1 0 d6 00  16 d6 0 04
1 0 d7 00  17 d7 0 04
1 0 d8 00  18 d8 0 04
1 0 d9 00  19 d9 0 04
1 0 da 00  1a da 0 04
1 0 db 00  1b db 0 04
1 0 dc 00  1c dc 0 04
1 0 dd 00  1d dd 0 04
1 0 de 00  1e de 0 04
1 0 df 00  1f df 2 04
1 0 ee 00  1f df 4 05
2 0 00 00  1e de 0 05

//--- verif/stackUnitTb.sv
////////////////////////////////////////////////////////////
// Trace-driven testbench for the operand stack subsystem.
// Reads commands and expected results from the trace file,
// drives one command per cycle and checks each result three
// edges later. Run from the project root.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stackUnitTb import stackPkg::*; ();

  localparam string tracePath   = "verif/stackTrace.txt";
  localparam int    clkPeriod   = 10;
  localparam int    resetCycles = 8;
  localparam int    pipeDepth   = 3;   // Edges from input to output
  localparam int    slackCycles = 20;

  typedef struct packed {
    stackOp_t                  op;
    frameOp_t                  frameOp;
    stackWord_t                data;
    stackIdx_t                 offset;
    stackIdx_t                 expIndex;
    stackWord_t                expTop;
    stackStatus_t              expStatus;
    logic [faultCountBits-1:0] expCount;
  } traceStep_t;

  logic                      clk = 1'b0;
  logic                      reset;
  stackOp_t                  op;
  frameOp_t                  frameOp;
  stackWord_t                data;
  stackIdx_t                 offset;
  stackIdx_t                 index;
  stackWord_t                top;
  stackWord_t                next;
  stackWord_t                third;
  stackStatus_t              status;
  logic                      faultSeen;
  stackStatus_t              firstFault;
  logic [faultCountBits-1:0] faultCount;

  traceStep_t                steps [$];
  traceStep_t                pending [$];   // Commands still in the pipeline
  logic                      traceLoaded = 1'b0;
  stackStatus_t              expFirst = stNone;
  logic [faultCountBits-1:0] lastCount = '0;
  stackWord_t                shadow [maxStack];   // Words written at each depth
  logic [maxStack-1:0]       shadowKnown = '0;

  stackUnit dut_i (
    .clk        (clk),
    .reset      (reset),
    .op         (op),
    .frameOp    (frameOp),
    .data       (data),
    .offset     (offset),
    .index      (index),
    .top        (top),
    .next       (next),
    .third      (third),
    .status     (status),
    .faultSeen  (faultSeen),
    .firstFault (firstFault),
    .faultCount (faultCount)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic failRun(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Testbench stopped at the first error");
  endtask

  task automatic checkIdx(input string name, input stackIdx_t got, input stackIdx_t exp);
    if (got !== exp)
      failRun($sformatf("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic checkWord(input string name, input stackWord_t got, input stackWord_t exp);
    if (got !== exp)
      failRun($sformatf("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp));
  endtask

  task automatic checkStatus(input string name, input stackStatus_t got,
                             input stackStatus_t exp);
    if (got !== exp)
      failRun($sformatf("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic checkCount(input string name, input logic [faultCountBits-1:0] got,
                            input logic [faultCountBits-1:0] exp);
    if (got !== exp)
      failRun($sformatf("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
      failRun($sformatf("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp));
  endtask

  // First fault is the status of the first step where the count rises
  task automatic checkStep(input traceStep_t s);
    logic refused;
    refused = (s.expCount > lastCount);  // A refused op writes nothing
    if (refused && (expFirst == stNone))
      expFirst = s.expStatus;
    lastCount = s.expCount;
    if (!refused) begin
      if ((s.op == opPush) || (s.op == opIndexPush) || (s.op == opReplace)) begin
        shadow[s.expIndex - 1'b1]      = s.data;
        shadowKnown[s.expIndex - 1'b1] = 1'b1;
      end else if (s.op == opUnderSet) begin
        shadowKnown = '0;  // Target depth is not visible from the trace
      end
    end
    checkIdx("index", index, s.expIndex);
    checkWord("top", top, s.expTop);
    if ((s.expIndex >= 2) && shadowKnown[s.expIndex - 2])
      checkWord("next", next, shadow[s.expIndex - 2]);
    if ((s.expIndex >= 3) && shadowKnown[s.expIndex - 3])
      checkWord("third", third, shadow[s.expIndex - 3]);
    checkStatus("status", status, s.expStatus);
    checkCount("faultCount", faultCount, s.expCount);
    checkFlag("faultSeen", faultSeen, s.expCount != '0);
    checkStatus("firstFault", firstFault, expFirst);
  endtask

  task automatic loadTrace();
    int         fd;
    int         got;
    int         opV, frameV, dataV, offV, idxV, topV, stV, cntV;
    string      line;
    traceStep_t s;
    fd = $fopen(tracePath, "r");
    if (fd == 0)
      failRun("Could not open the trace file");
    while (!$feof(fd)) begin
      line = "";
      got  = $fgets(line, fd);
      if ((got != 0) && (line.len() > 1) && (line.getc(0) != "#")) begin  // Skip notes
        got = $sscanf(line, "%h %h %h %h %h %h %h %h",
                      opV, frameV, dataV, offV, idxV, topV, stV, cntV);
        if (got != 8) begin
          failRun($sformatf("Trace line has %0d fields instead of 8: %s", got, line));
        end else begin
          s.op        = stackOp_t'(opV[2:0]);
          s.frameOp   = frameOp_t'(frameV[1:0]);
          s.data      = dataV[dataWidth-1:0];
          s.offset    = offV[depthBits:0];
          s.expIndex  = idxV[depthBits:0];
          s.expTop    = topV[dataWidth-1:0];
          s.expStatus = stackStatus_t'(stV[2:0]);
          s.expCount  = cntV[faultCountBits-1:0];
          steps.push_back(s);
        end
      end
    end
    $fclose(fd);
    traceLoaded = 1'b1;
  endtask

  // Watchdog sized from the trace length
  initial begin
    wait (traceLoaded);
    #((steps.size() + slackCycles) * clkPeriod);
    failRun("Watchdog expired before the trace finished");
  end

  initial begin
    reset   = 1'b1;
    op      = opNone;
    frameOp = frameNone;
    data    = '0;
    offset  = '0;
    loadTrace();
    if (steps.size() == 0)
      failRun("Trace file holds no steps");
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < steps.size() + pipeDepth; i++) begin
      @(posedge clk);
      if (i < steps.size()) begin
        op      <= steps[i].op;
        frameOp <= steps[i].frameOp;
        data    <= steps[i].data;
        offset  <= steps[i].offset;
        pending.push_back(steps[i]);
      end else begin
        op      <= opNone;   // Idle while the pipeline drains
        frameOp <= frameNone;
      end
      @(negedge clk);
      if (i >= pipeDepth)
        checkStep(pending.pop_front());
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/stackPkg.sv
logic/stackIfc.sv
logic/frameTracker.sv
logic/superStack.sv
logic/faultMonitor.sv
logic/stackUnit.sv
verif/stackUnitTb.sv
